//--- common/pairing_pkg.sv
package pairing_pkg;

    ////////////////////////////////////////
    // Sample and channel sizes
    ////////////////////////////////////////

    localparam int DATA_WIDTH   = 16;
    localparam int NUM_CHANNELS = 10;

    // One channel sample
    typedef logic [DATA_WIDTH-1:0] sample_t;

    // Channel number, zero based
    typedef logic [3:0] chan_idx_t;

    // All channels of one cycle, channel 0 in the lowest slot
    typedef sample_t [NUM_CHANNELS-1:0] sample_bus_t;

    ////////////////////////////////////////
    // Lane split by first channel
    ////////////////////////////////////////

    // Low lane, first channels 0 to 2, 27 pairs
    localparam chan_idx_t LO_FIRST_MIN = 4'd0;
    localparam chan_idx_t LO_FIRST_MAX = 4'd2;

    // High lane, first channels 3 to 9, 28 pairs
    localparam chan_idx_t HI_FIRST_MIN = 4'd3;
    localparam chan_idx_t HI_FIRST_MAX = 4'd9;

endpackage

//--- rtl/pair_sequencer.sv
`timescale 1ns/100ps

module pair_sequencer #(
    parameter pairing_pkg::chan_idx_t FIRST_MIN = 4'd0,
    parameter pairing_pkg::chan_idx_t FIRST_MAX = 4'd2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sample_valid,
    output logic                   pair_valid,
    output pairing_pkg::chan_idx_t first_chan,
    output pairing_pkg::chan_idx_t second_chan
);

    // IDLE waits for a gap in sample_valid before a run may start,
    // RUN walks the pairs, DONE holds after the lane's last pair
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } seq_state_t;

    localparam pairing_pkg::chan_idx_t LAST_CHAN =
        pairing_pkg::chan_idx_t'(pairing_pkg::NUM_CHANNELS - 1);

    seq_state_t             state_q;
    seq_state_t             state_d;
    pairing_pkg::chan_idx_t first_q;
    pairing_pkg::chan_idx_t first_d;
    pairing_pkg::chan_idx_t second_q;
    pairing_pkg::chan_idx_t second_d;
    pairing_pkg::chan_idx_t first_inc;
    logic                   row_end;
    logic                   lane_end;

    ////////////////////////////////////////
    // Pair position
    ////////////////////////////////////////

    // Second channel has reached the top channel
    assign row_end   = (second_q == LAST_CHAN);
    // Pair (FIRST_MAX, last channel)
    assign lane_end  = row_end && (first_q == FIRST_MAX);
    assign first_inc = first_q + 4'd1;

    ////////////////////////////////////////
    // Next state and indices
    ////////////////////////////////////////

    always_comb begin
        state_d  = state_q;
        first_d  = first_q;
        second_d = second_q;

        if (!sample_valid) begin
            // Gap between runs, rearm at the first pair
            state_d  = RUN;
            first_d  = FIRST_MIN;
            second_d = FIRST_MIN;
        end else begin
            case (state_q)
                RUN: begin
                    if (lane_end) begin
                        state_d = DONE;
                    end else if (row_end) begin
                        // Next row starts on the diagonal
                        first_d  = first_inc;
                        second_d = first_inc;
                    end else begin
                        second_d = second_q + 4'd1;
                    end
                end
                IDLE: begin
                    state_d = IDLE;
                end
                DONE: begin
                    state_d = DONE;
                end
                default: begin
                    state_d = IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // State and index registers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            first_q  <= FIRST_MIN;
            second_q <= FIRST_MIN;
        end else begin
            state_q  <= state_d;
            first_q  <= first_d;
            second_q <= second_d;
        end
    end

    // Outputs
    assign pair_valid  = (state_q == RUN) && sample_valid;
    assign first_chan  = first_q;
    assign second_chan = second_q;

endmodule

//--- rtl/channel_crossbar.sv
`timescale 1ns/100ps

module channel_crossbar (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  pairing_pkg::sample_bus_t in_samples,
    output logic                     sample_valid,
    input  pairing_pkg::chan_idx_t   lo_first,
    input  pairing_pkg::chan_idx_t   lo_second,
    input  pairing_pkg::chan_idx_t   hi_first,
    input  pairing_pkg::chan_idx_t   hi_second,
    output pairing_pkg::sample_t     lo_sample_a,
    output pairing_pkg::sample_t     lo_sample_b,
    output pairing_pkg::sample_t     hi_sample_a,
    output pairing_pkg::sample_t     hi_sample_b
);

    logic                     valid_q;
    pairing_pkg::sample_bus_t samples_q;

    // Registered sample of one channel, channel 0 for an out of range index
    function automatic pairing_pkg::sample_t pick_channel(
        input pairing_pkg::sample_bus_t bus,
        input pairing_pkg::chan_idx_t   idx
    );
        pairing_pkg::sample_t result;
        if (int'(idx) < pairing_pkg::NUM_CHANNELS) begin
            result = bus[idx];
        end else begin
            result = bus[0];
        end
        return result;
    endfunction

    ////////////////////////////////////////
    // Input register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            samples_q <= '0;
        end else begin
            valid_q   <= in_valid;
            samples_q <= in_samples;
        end
    end

    assign sample_valid = valid_q;

    ////////////////////////////////////////
    // Channel selectors
    ////////////////////////////////////////

    // Low lane
    always_comb begin
        lo_sample_a = pick_channel(samples_q, lo_first);
    end

    always_comb begin
        lo_sample_b = pick_channel(samples_q, lo_second);
    end

    // High lane
    always_comb begin
        hi_sample_a = pick_channel(samples_q, hi_first);
    end

    always_comb begin
        hi_sample_b = pick_channel(samples_q, hi_second);
    end

endmodule

//--- rtl/channel_pair_gen.sv
`timescale 1ns/100ps

module channel_pair_gen (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  pairing_pkg::sample_bus_t in_samples,
    output logic                     lo_valid,
    output pairing_pkg::sample_t     lo_sample_a,
    output pairing_pkg::sample_t     lo_sample_b,
    output logic                     hi_valid,
    output pairing_pkg::sample_t     hi_sample_a,
    output pairing_pkg::sample_t     hi_sample_b
);

    logic                   sample_valid;
    pairing_pkg::chan_idx_t lo_first;
    pairing_pkg::chan_idx_t lo_second;
    pairing_pkg::chan_idx_t hi_first;
    pairing_pkg::chan_idx_t hi_second;

    ////////////////////////////////////////
    // Sample register and selectors
    ////////////////////////////////////////

    channel_crossbar i_crossbar (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_samples   (in_samples),
        .sample_valid (sample_valid),
        .lo_first     (lo_first),
        .lo_second    (lo_second),
        .hi_first     (hi_first),
        .hi_second    (hi_second),
        .lo_sample_a  (lo_sample_a),
        .lo_sample_b  (lo_sample_b),
        .hi_sample_a  (hi_sample_a),
        .hi_sample_b  (hi_sample_b)
    );

    ////////////////////////////////////////
    // Lane sequencers
    ////////////////////////////////////////

    // First channels 0 to 2
    pair_sequencer #(
        .FIRST_MIN (pairing_pkg::LO_FIRST_MIN),
        .FIRST_MAX (pairing_pkg::LO_FIRST_MAX)
    ) i_lo_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .pair_valid   (lo_valid),
        .first_chan   (lo_first),
        .second_chan  (lo_second)
    );

    // First channels 3 to 9
    pair_sequencer #(
        .FIRST_MIN (pairing_pkg::HI_FIRST_MIN),
        .FIRST_MAX (pairing_pkg::HI_FIRST_MAX)
    ) i_hi_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .pair_valid   (hi_valid),
        .first_chan   (hi_first),
        .second_chan  (hi_second)
    );

endmodule

//--- sim/pair_model.svh
`ifndef PAIR_MODEL_SVH
`define PAIR_MODEL_SVH

////////////////////////////////////////
// Reference model state
////////////////////////////////////////

// Input valid and samples seen at the last rising edge
logic                     model_valid   = 1'b0;
pairing_pkg::sample_bus_t model_samples = '0;
// Cycle number within the current run
int                       model_k       = 0;
int                       check_count   = 0;
int                       error_count   = 0;

// Pairs (a, b) with a in the lane's first range and b from a to the top channel
function automatic int pair_count(input int first_min, input int first_max);
    int n;
    n = 0;
    for (int a = first_min; a <= first_max; a++) begin
        n += pairing_pkg::NUM_CHANNELS - a;
    end
    return n;
endfunction

// Pair number k of a lane, a ascending and b ascending from a
function automatic void nth_pair(
    input  int                     first_min,
    input  int                     first_max,
    input  int                     k,
    output pairing_pkg::chan_idx_t a_idx,
    output pairing_pkg::chan_idx_t b_idx
);
    int n;
    n     = 0;
    a_idx = pairing_pkg::chan_idx_t'(first_min);
    b_idx = pairing_pkg::chan_idx_t'(first_min);
    for (int a = first_min; a <= first_max; a++) begin
        for (int b = a; b < pairing_pkg::NUM_CHANNELS; b++) begin
            if (n == k) begin
                a_idx = pairing_pkg::chan_idx_t'(a);
                b_idx = pairing_pkg::chan_idx_t'(b);
            end
            n++;
        end
    end
endfunction

task automatic check_value(
    input string       what,
    input logic [31:0] expected,
    input logic [31:0] actual
);
    check_count++;
    if (expected !== actual) begin
        error_count++;
        $display("ERR at %0d ns: %s expected %0h, got %0h", $time, what, expected, actual);
    end
endtask

// Called at every rising edge
task automatic model_step();
    if (!rst_n) begin
        model_valid   = 1'b0;
        model_samples = '0;
        model_k       = 0;
    end else begin
        if (in_valid && model_valid) begin
            model_k = model_k + 1;
        end else begin
            model_k = 0;
        end
        model_valid   = in_valid;
        model_samples = in_samples;
    end
endtask

task automatic check_lane(
    input string                lane,
    input int                   first_min,
    input int                   first_max,
    input logic                 act_valid,
    input pairing_pkg::sample_t act_a,
    input pairing_pkg::sample_t act_b
);
    pairing_pkg::chan_idx_t a_idx;
    pairing_pkg::chan_idx_t b_idx;
    logic                   exp_valid;
    exp_valid = model_valid && (model_k < pair_count(first_min, first_max));
    check_value({lane, " valid"}, 32'(exp_valid), 32'(act_valid));
    if (exp_valid) begin
        nth_pair(first_min, first_max, model_k, a_idx, b_idx);
        check_value({lane, " sample a"}, 32'(model_samples[a_idx]), 32'(act_a));
        check_value({lane, " sample b"}, 32'(model_samples[b_idx]), 32'(act_b));
    end
endtask

`endif

//--- sim/tb_channel_pair_gen.sv
`timescale 1ns/100ps

module tb_channel_pair_gen;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_BURSTS   = 60;
    localparam int MAX_BURST    = 40;
    localparam int MAX_IDLE     = 3;
    // Every burst at its longest, plus reset and some slack
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + NUM_BURSTS * (MAX_BURST + MAX_IDLE) + 20) * CLK_PERIOD;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    pairing_pkg::sample_bus_t in_samples;
    logic                     lo_valid;
    pairing_pkg::sample_t     lo_sample_a;
    pairing_pkg::sample_t     lo_sample_b;
    logic                     hi_valid;
    pairing_pkg::sample_t     hi_sample_a;
    pairing_pkg::sample_t     hi_sample_b;

    `include "pair_model.svh"

    channel_pair_gen i_channel_pair_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_samples  (in_samples),
        .lo_valid    (lo_valid),
        .lo_sample_a (lo_sample_a),
        .lo_sample_b (lo_sample_b),
        .hi_valid    (hi_valid),
        .hi_sample_a (hi_sample_a),
        .hi_sample_b (hi_sample_b)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic fill_random_samples();
        for (int c = 0; c < pairing_pkg::NUM_CHANNELS; c++) begin
            in_samples[pairing_pkg::chan_idx_t'(c)] = pairing_pkg::sample_t'($urandom);
        end
    endtask

    task automatic drive_cycle(input logic valid);
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = valid;
        fill_random_samples();
    endtask

    ////////////////////////////////////////
    // Model and output checks
    ////////////////////////////////////////

    always @(posedge clk) begin
        model_step();
    end

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        check_lane("low lane", int'(pairing_pkg::LO_FIRST_MIN), int'(pairing_pkg::LO_FIRST_MAX),
                   lo_valid, lo_sample_a, lo_sample_b);
        check_lane("high lane", int'(pairing_pkg::HI_FIRST_MIN), int'(pairing_pkg::HI_FIRST_MAX),
                   hi_valid, hi_sample_a, hi_sample_b);
    end

    initial begin : stimulus
        int unsigned burst_len;
        int unsigned idle_len;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_samples = '0;
        void'($urandom(32'hea18));
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        // Idle cycles let both lanes arm before the first burst
        repeat (2) drive_cycle(1'b0);
        for (int run = 0; run < NUM_BURSTS; run++) begin
            burst_len = 1 + $urandom % MAX_BURST;
            idle_len  = 1 + $urandom % MAX_IDLE;
            repeat (burst_len) drive_cycle(1'b1);
            repeat (idle_len) drive_cycle(1'b0);
        end
        repeat (3) drive_cycle(1'b0);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #WATCHDOG_NS;
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

//--- build.f
+incdir+sim
common/pairing_pkg.sv
rtl/pair_sequencer.sv
rtl/channel_crossbar.sv
rtl/channel_pair_gen.sv
sim/tb_channel_pair_gen.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the channel pair generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --top-module tb_channel_pair_gen -f build.f \
    && ./obj_dir/Vtb_channel_pair_gen > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Compile or simulation error"; exit 1; }

cat sim.log

grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Test completed successfully" sim.log \
    || { echo "Simulation ended without a result"; exit 1; }

echo "Simulation PASSED"
exit 0
